/* hdl/acc_cfg_pkg.sv */
package acc_cfg_pkg;

    ////////////////////////////////////////
    // stream and frame widths
    ////////////////////////////////////////

    // one stream word, header or sample
    localparam int WORD_W = 64;

    // sample count taken from the low end of the header
    localparam int LEN_W = 32;

    ////////////////////////////////////////
    // queue sizing
    ////////////////////////////////////////

    // same depth for the input and the output queue
    localparam int FIFO_DEPTH = 16;

    // must stay log2 of the depth, pointers wrap on their own
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    ////////////////////////////////////////
    // frame sequencing
    ////////////////////////////////////////

    // idle    accumulation not enabled
    // header  waiting for the length word
    // samples popping the remaining samples
    // hold    frame closed, waiting for enable to drop
    typedef enum logic [1:0] {
        idle    = 2'd0,
        header  = 2'd1,
        samples = 2'd2,
        hold    = 2'd3
    } frame_state_t;

endpackage

/* hdl/acc_types_pkg.sv */
package acc_types_pkg;

    import acc_cfg_pkg::*;

    ////////////////////////////////////////
    // popped stream word
    ////////////////////////////////////////

    // header view, only the low LEN_W bits carry the count
    typedef struct packed {
        logic [WORD_W-LEN_W-1:0] pad;
        logic [LEN_W-1:0]        len;
    } header_word_t;

    // the same word read either as a length or as a sample
    typedef union packed {
        logic signed [WORD_W-1:0] sample;
        header_word_t             hdr;
    } stream_word_u;

    ////////////////////////////////////////
    // frame_counter to the other blocks
    ////////////////////////////////////////

    // pop and is_header describe the current cycle,
    // frame_done is a registered one cycle pulse
    typedef struct packed {
        logic pop;
        logic is_header;
        logic frame_done;
    } pop_info_t;

    ////////////////////////////////////////
    // sum_datapath to result_emitter
    ////////////////////////////////////////

    typedef struct packed {
        logic signed [WORD_W-1:0] sum;
        logic                     ready;
    } result_t;

endpackage

/* hdl/stream_fifo.sv */
module stream_fifo
    import acc_cfg_pkg::*;
(
    input  logic              sys_clk,
    input  logic              sys_rst_n,

    // write side
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [WORD_W-1:0] in_data,

    // read side
    output logic              out_valid,
    input  logic              out_ready,
    output logic [WORD_W-1:0] out_data
);

    logic [WORD_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic [FIFO_AW:0]   count_next;
    logic               push;
    logic               pop;
    logic               in_ready_q;

    assign push = in_valid && in_ready_q;
    assign pop  = out_valid && out_ready;

    // occupancy after this cycle's transfers
    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            in_ready_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // registered full flag, stays low while in reset
            in_ready_q <= (count_next != FIFO_DEPTH);
        end
    end

    // storage
    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // head of queue is visible right after the write edge
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign in_ready  = in_ready_q;

endmodule

/* hdl/frame_counter.sv */
module frame_counter
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
(
    input  logic         sys_clk,
    input  logic         sys_rst_n,

    input  logic         accu_en,

    // head of the input queue
    input  logic         word_valid,
    input  stream_word_u word,

    output pop_info_t    pop_info
);

    frame_state_t     state;
    logic [LEN_W-1:0] remaining;
    logic             pop_now;
    logic             header_pop;
    logic             sample_pop;
    logic             frame_done_q;

    ////////////////////////////////////////
    // pop decision
    ////////////////////////////////////////

    // one word per cycle while a frame is open
    assign pop_now = word_valid && accu_en &&
                     ((state == header) || (state == samples));

    assign header_pop = pop_now && (state == header);
    assign sample_pop = pop_now && (state == samples);

    ////////////////////////////////////////
    // frame state and sample count
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state        <= idle;
            remaining    <= '0;
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= 1'b0;
            if (!accu_en) begin
                // enable dropped, abandon whatever was in progress
                state <= idle;
            end else begin
                case (state)
                    idle: begin
                        state <= header;
                    end
                    header: begin
                        if (header_pop) begin
                            remaining <= word.hdr.len;
                            if (word.hdr.len == '0) begin
                                // empty frame closes at once, sum stays 0
                                state        <= hold;
                                frame_done_q <= 1'b1;
                            end else begin
                                state <= samples;
                            end
                        end
                    end
                    samples: begin
                        if (sample_pop) begin
                            remaining <= remaining - 1'b1;
                            if (remaining == LEN_W'(1)) begin
                                state        <= hold;
                                frame_done_q <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        // hold, one frame per enable
                        state <= hold;
                    end
                endcase
            end
        end
    end

    assign pop_info.pop        = pop_now;
    assign pop_info.is_header  = header_pop;
    assign pop_info.frame_done = frame_done_q;

endmodule

/* hdl/sum_datapath.sv */
module sum_datapath
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
(
    input  logic         sys_clk,
    input  logic         sys_rst_n,

    // word leaving the input queue
    input  stream_word_u word,
    input  pop_info_t    pop_info,

    output result_t      result
);

    logic signed [WORD_W-1:0] sum_q;
    logic                     ready_q;

    ////////////////////////////////////////
    // running sum
    ////////////////////////////////////////

    // wraps modulo 2^64, no saturation
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sum_q <= '0;
        end else if (pop_info.pop) begin
            if (pop_info.is_header) begin
                sum_q <= '0;
            end else begin
                sum_q <= sum_q + word.sample;
            end
        end
    end

    // complete once the frame end pulse is seen,
    // stays up until the next header arrives
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ready_q <= 1'b0;
        end else if (pop_info.pop && pop_info.is_header) begin
            ready_q <= 1'b0;
        end else if (pop_info.frame_done) begin
            ready_q <= 1'b1;
        end
    end

    assign result.sum   = sum_q;
    assign result.ready = ready_q;

endmodule

/* hdl/result_emitter.sv */
module result_emitter
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
(
    input  logic              sys_clk,
    input  logic              sys_rst_n,

    input  logic              accu_en,
    input  pop_info_t         pop_info,
    input  result_t           result,

    // output queue write side
    input  logic              push_ready,
    output logic              push_valid,
    output logic [WORD_W-1:0] push_data,

    output logic              accu_finished
);

    logic pending;
    logic pushed;
    logic push_fire;

    assign push_valid = pending && result.ready;
    assign push_fire  = push_valid && push_ready;
    assign push_data  = result.sum;

    ////////////////////////////////////////
    // result hand-off
    ////////////////////////////////////////

    // waits here as long as the output queue is full
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pending <= 1'b0;
        end else if (pop_info.frame_done) begin
            pending <= 1'b1;
        end else if (push_fire) begin
            pending <= 1'b0;
        end
    end

    // remembers that this enable period already produced its result
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pushed <= 1'b0;
        end else if (!accu_en) begin
            pushed <= 1'b0;
        end else if (push_fire) begin
            pushed <= 1'b1;
        end
    end

    // high when disabled, low from enable until the sum is queued
    assign accu_finished = !accu_en || pushed;

endmodule

/* hdl/accumulator_top.sv */
module accumulator_top
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
(
    input  logic              sys_clk,
    input  logic              sys_rst_n,

    // control levels
    input  logic              accu_en,
    output logic              accu_finished,

    // input stream, header then samples
    input  logic              s_valid,
    output logic              s_ready,
    input  logic [WORD_W-1:0] s_data,

    // output stream, one sum per frame
    output logic              m_valid,
    input  logic              m_ready,
    output logic [WORD_W-1:0] m_data
);

    stream_word_u      in_word;
    logic              in_word_valid;
    pop_info_t         pop_info;
    result_t           result;
    logic              push_valid;
    logic              push_ready;
    logic [WORD_W-1:0] push_data;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    stream_fifo in_fifo (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_valid  (s_valid),
        .in_ready  (s_ready),
        .in_data   (s_data),
        .out_valid (in_word_valid),
        .out_ready (pop_info.pop),
        .out_data  (in_word)
    );

    frame_counter frame_counter_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .accu_en    (accu_en),
        .word_valid (in_word_valid),
        .word       (in_word),
        .pop_info   (pop_info)
    );

    sum_datapath sum_datapath_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .word      (in_word),
        .pop_info  (pop_info),
        .result    (result)
    );

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    result_emitter result_emitter_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .accu_en       (accu_en),
        .pop_info      (pop_info),
        .result        (result),
        .push_ready    (push_ready),
        .push_valid    (push_valid),
        .push_data     (push_data),
        .accu_finished (accu_finished)
    );

    stream_fifo out_fifo (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_valid  (push_valid),
        .in_ready  (push_ready),
        .in_data   (push_data),
        .out_valid (m_valid),
        .out_ready (m_ready),
        .out_data  (m_data)
    );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
    output logic sys_clk,
    output logic sys_rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        sys_clk = 1'b0;
        forever #HALF_PERIOD sys_clk = ~sys_clk;
    end

    // release away from the rising edge
    initial begin
        sys_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;
    end

endmodule

/* tests/accumulator_tb.sv */
module accumulator_tb
    import acc_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 500;

    logic              sys_clk;
    logic              sys_rst_n;
    logic              accu_en;
    logic              accu_finished;
    logic              s_valid;
    logic              s_ready;
    logic [WORD_W-1:0] s_data;
    logic              m_valid;
    logic              m_ready;
    logic [WORD_W-1:0] m_data;

    logic [WORD_W-1:0] expected_q [$];
    integer            seed = 96;
    int                value_errors = 0;
    int                timeouts = 0;
    int                extra_outputs = 0;

    tb_clock_gen clock_gen_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    accumulator_top accumulator_top_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .accu_en       (accu_en),
        .accu_finished (accu_finished),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .s_data        (s_data),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .m_data        (m_data)
    );

    ////////////////////////////////////////
    // reference model and checking
    ////////////////////////////////////////

    // plain two's complement sum that wraps at 64 bits
    function automatic logic [WORD_W-1:0] ref_sum(input logic [WORD_W-1:0] samples [$]);
        logic [WORD_W-1:0] acc;
        acc = '0;
        foreach (samples[i]) begin
            acc = acc + samples[i];
        end
        return acc;
    endfunction

    task automatic check_value(input logic [WORD_W-1:0] actual,
                               input logic [WORD_W-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            value_errors++;
        end
    endtask

    // every accepted output word must match the oldest pending sum
    always @(posedge sys_clk) begin
        if (sys_rst_n && m_valid && m_ready) begin
            if (expected_q.size() == 0) begin
                $display("output word %h accepted at %0t with no sum pending", m_data, $time);
                extra_outputs++;
            end else begin
                check_value(m_data, expected_q.pop_front(), "m_data sum");
            end
        end
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic send_word(input logic [WORD_W-1:0] data);
        int waited;
        waited = 0;
        @(negedge sys_clk);
        s_valid = 1'b1;
        s_data  = data;
        @(posedge sys_clk);
        while (!s_ready && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge sys_clk);
        end
        if (!s_ready) begin
            $display("timed out at %0t waiting for the input stream to take a word", $time);
            timeouts++;
        end
    endtask

    task automatic insert_gap(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            s_valid = 1'b0;
            @(posedge sys_clk);
        end
    endtask

    task automatic stream_idle();
        @(negedge sys_clk);
        s_valid = 1'b0;
    endtask

    // expected sum is queued before the header and samples go out
    task automatic load_frame(input logic [WORD_W-1:0] header_word, input int count,
                              input int max_gap);
        logic [WORD_W-1:0] samples [$];
        logic [WORD_W-1:0] value;
        int                gap;
        for (int i = 0; i < count; i++) begin
            value = {$random(seed), $random(seed)};
            samples.push_back(value);
        end
        expected_q.push_back(ref_sum(samples));
        send_word(header_word);
        foreach (samples[i]) begin
            if (max_gap > 0) begin
                gap = ($random(seed) & 32'h7fff_ffff) % (max_gap + 1);
                insert_gap(gap);
            end
            send_word(samples[i]);
        end
        stream_idle();
    endtask

    task automatic enable_frame();
        @(negedge sys_clk);
        accu_en = 1'b1;
        @(posedge sys_clk);
        check_value(accu_finished, 1'b0, "accu_finished after enable");
    endtask

    task automatic disable_frame();
        @(negedge sys_clk);
        accu_en = 1'b0;
        @(posedge sys_clk);
        check_value(accu_finished, 1'b1, "accu_finished while disabled");
    endtask

    // accu_finished must stay low until the sum reaches the output
    task automatic wait_for_result();
        int waited;
        waited = 0;
        @(posedge sys_clk);
        while (!m_valid && waited < TIMEOUT_CYCLES) begin
            check_value(accu_finished, 1'b0, "accu_finished before result");
            waited++;
            @(posedge sys_clk);
        end
        if (!m_valid) begin
            $display("timed out at %0t waiting for a result on the output stream", $time);
            timeouts++;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge sys_clk);
        end
        if (expected_q.size() != 0) begin
            $display("timed out at %0t waiting for the result to be accepted", $time);
            timeouts++;
        end
        @(posedge sys_clk);
        check_value(accu_finished, 1'b1, "accu_finished after result accepted");
    endtask

    task automatic finish_frame();
        wait_for_result();
        wait_drained();
        disable_frame();
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int                n;
        int                waited;
        logic [WORD_W-1:0] held;

        accu_en = 1'b0;
        s_valid = 1'b0;
        s_data  = '0;
        m_ready = 1'b1;

        waited = 0;
        while (sys_rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge sys_clk);
        end
        if (sys_rst_n !== 1'b1) begin
            $display("timed out waiting for reset to be released");
            timeouts++;
        end
        @(posedge sys_clk);
        check_value(accu_finished, 1'b1, "accu_finished after reset");
        check_value(m_valid, 1'b0, "m_valid after reset");

        // random frames with gaps on s_valid in the later ones
        for (int f = 0; f < 6; f++) begin
            n = 1 + (($random(seed) & 32'h7fff_ffff) % 12);
            enable_frame();
            load_frame(WORD_W'(n), n, (f >= 3) ? 3 : 0);
            finish_frame();
        end

        // empty frame and then a header with junk in the upper half
        enable_frame();
        load_frame('0, 0, 0);
        finish_frame();
        enable_frame();
        load_frame({32'hdead_beef, 32'd3}, 3, 0);
        finish_frame();

        // output back-pressure
        @(negedge sys_clk);
        m_ready = 1'b0;
        enable_frame();
        load_frame(WORD_W'(5), 5, 0);
        wait_for_result();
        held = m_data;
        repeat (8) begin
            @(posedge sys_clk);
            check_value(m_valid, 1'b1, "m_valid held under back-pressure");
            check_value(m_data, held, "m_data held under back-pressure");
        end
        @(negedge sys_clk);
        m_ready = 1'b1;
        wait_drained();
        disable_frame();

        // fill the input queue while disabled and then run it as a frame
        @(posedge sys_clk);
        check_value(s_ready, 1'b1, "s_ready with empty input queue");
        load_frame(WORD_W'(FIFO_DEPTH - 1), FIFO_DEPTH - 1, 0);
        @(posedge sys_clk);
        check_value(s_ready, 1'b0, "s_ready with full input queue");
        check_value(accu_finished, 1'b1, "accu_finished while disabled");
        enable_frame();
        finish_frame();

        repeat (4) @(posedge sys_clk);
        if (expected_q.size() != 0) begin
            $display("%0d expected sums never appeared on the output", expected_q.size());
            extra_outputs++;
        end

        $display("value errors: %0d, timeouts: %0d, output mismatches in count: %0d",
                 value_errors, timeouts, extra_outputs);
        if (value_errors == 0 && timeouts == 0 && extra_outputs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/acc_cfg_pkg.sv
hdl/acc_types_pkg.sv
hdl/stream_fifo.sv
hdl/frame_counter.sv
hdl/sum_datapath.sv
hdl/result_emitter.sv
hdl/accumulator_top.sv
tests/tb_clock_gen.sv
tests/accumulator_tb.sv
